/* include/elink_consts.svh */
`ifndef ELINK_CONSTS_SVH
`define ELINK_CONSTS_SVH

// ####################################################################
// Link packet and address map
// ####################################################################

// Flat packet width on the link
`define ELINK_PW 104

// Chip ID in dstaddr[31:20]
`define ELINK_ID 12'h800

// Receive register group in dstaddr[19:16]
`define ELINK_GROUP_RX 4'hE

// Read-response register word offset in dstaddr[5:2]
`define ELINK_RXRR_OFS 4'h8

// ####################################################################
// Queues and watchdog
// ####################################################################

`define ELINK_FIFO_DEPTH 8
// Watchdog limit after reset, in cycles
`define ELINK_TIMEOUT_DEF 32'd64
// Payload of a synthesized timeout response
`define ELINK_ERR_DATA 32'hDEADBEEF

`endif

/* rtl/emesh_pkg.sv */
package emesh_pkg;

  // Transfer size of one link access
  typedef enum logic [1:0] {
    DM_BYTE   = 2'b00,
    DM_HALF   = 2'b01,
    DM_WORD   = 2'b10,
    DM_DOUBLE = 2'b11
  } emesh_datamode_e;

  // ####################################################################
  // Link packet, 104 bits, MSB first
  // ####################################################################

  typedef struct packed {
    logic [31:0]     srcaddr;
    logic [31:0]     data;
    logic [31:0]     dstaddr;
    logic [3:0]      ctrlmode;
    emesh_datamode_e datamode;
    logic            write;
    // Unused, keeps the packet at 104 bits
    logic            spare;
  } emesh_packet_t;

  // APB register select, from paddr[7:2]
  typedef enum logic [5:0] {
    REG_CTRL     = 6'd0,
    REG_TIMEOUT  = 6'd1,
    REG_STATUS   = 6'd2,
    // Offsets 16 to 31 all land here
    REG_MMU_BASE = 6'd16,
    REG_NONE     = 6'd63
  } apb_reg_e;

endpackage

/* rtl/erx_fifo.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module erx_fifo #(
  parameter int DEPTH = `ELINK_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_access,
  input  emesh_pkg::emesh_packet_t in_packet,
  output logic                     in_wait,
  output logic                     out_access,
  output emesh_pkg::emesh_packet_t out_packet,
  input  logic                     out_wait
);
  import emesh_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Storage
  emesh_packet_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // Fill level, one bit wider than the pointers
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  // Push side stalls on full only
  assign in_wait    = (count == (AW+1)'(DEPTH));
  assign out_access = (count != '0);
  // Head of queue shown directly
  assign out_packet = mem[rd_ptr];

  assign push = in_access & ~in_wait;
  assign pop  = out_access & ~out_wait;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Level only moves when exactly one side fires
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/erx_mmu.sv */
`timescale 1ns/1ps

module erx_mmu (
  input  logic                     clk,
  input  logic                     rst,
  // Packet stream in
  input  logic                     in_access,
  input  emesh_pkg::emesh_packet_t in_packet,
  output logic                     in_wait,
  // Remapped stream out
  output logic                     out_access,
  output emesh_pkg::emesh_packet_t out_packet,
  input  logic                     out_wait,
  // Control and table port
  input  logic                     mmu_enable,
  input  logic                     tbl_we,
  input  logic [3:0]               tbl_idx,
  input  logic [11:0]              tbl_data,
  output logic [11:0]              tbl_rdata
);
  import emesh_pkg::*;

  // ####################################################################
  // Translation table
  // ####################################################################

  // 16 entries, one per dstaddr[31:28] region
  logic [11:0]   tbl [16];
  emesh_packet_t remap_pkt;
  logic          slot_full;

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      tbl[tbl_idx] <= tbl_data;
    end
  end

  // Readback for APB, no register stage
  assign tbl_rdata = tbl[tbl_idx];

  // ####################################################################
  // Remap and output slot
  // ####################################################################

  always_comb begin
    remap_pkt = in_packet;
    // Upper 12 bits of the address come from the table
    if (mmu_enable) begin
      remap_pkt.dstaddr[31:20] = tbl[in_packet.dstaddr[31:28]];
    end
  end

  // Slot frees up whenever the consumer takes it
  assign in_wait    = slot_full & out_wait;
  assign out_access = slot_full;

  // Slot valid
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_full <= 1'b0;
    end else if (!in_wait) begin
      slot_full <= in_access;
    end
  end

  // Slot payload
  always_ff @(posedge clk) begin
    if (!in_wait && in_access) begin
      out_packet <= remap_pkt;
    end
  end

endmodule

/* rtl/erx_cfg.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module erx_cfg (
  input  logic        clk,
  input  logic        rst,
  // APB slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // MMU control and table port
  output logic        mmu_enable,
  output logic        mmu_tbl_we,
  output logic [3:0]  mmu_tbl_idx,
  output logic [11:0] mmu_tbl_data,
  input  logic [11:0] mmu_tbl_rdata,
  // Watchdog events
  input  logic        rd_push,
  input  logic        rr_push,
  output logic        timeout
);
  import emesh_pkg::*;

  apb_reg_e    reg_sel;
  logic        apb_wr;
  logic [31:0] timeout_lim;
  logic [15:0] timeout_cnt;
  logic        pending;
  logic [31:0] wd_cnt;

  // ####################################################################
  // APB decode and registers
  // ####################################################################

  always_comb begin
    if (paddr[7:6] == 2'b01) begin
      reg_sel = REG_MMU_BASE;
    end else begin
      case (paddr[7:2])
        6'd0:    reg_sel = REG_CTRL;
        6'd1:    reg_sel = REG_TIMEOUT;
        6'd2:    reg_sel = REG_STATUS;
        default: reg_sel = REG_NONE;
      endcase
    end
  end

  // Zero wait states, never an error
  assign pready  = 1'b1;
  assign pslverr = 1'b0;
  assign apb_wr  = psel & penable & pwrite;

  // Table writes pass straight through
  assign mmu_tbl_we   = apb_wr & (reg_sel == REG_MMU_BASE);
  assign mmu_tbl_idx  = paddr[5:2];
  assign mmu_tbl_data = pwdata[11:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      mmu_enable  <= 1'b0;
      timeout_lim <= `ELINK_TIMEOUT_DEF;
    end else if (apb_wr) begin
      if (reg_sel == REG_CTRL) mmu_enable <= pwdata[0];
      if (reg_sel == REG_TIMEOUT) timeout_lim <= pwdata;
    end
  end

  always_comb begin
    case (reg_sel)
      REG_CTRL:     prdata = {31'h0, mmu_enable};
      REG_TIMEOUT:  prdata = timeout_lim;
      // Sticky count high, pending flag low
      REG_STATUS:   prdata = {timeout_cnt, 15'h0, pending};
      REG_MMU_BASE: prdata = {20'h0, mmu_tbl_rdata};
      default:      prdata = 32'h0;
    endcase
  end

  // ####################################################################
  // Read-response watchdog
  // ####################################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      wd_cnt  <= '0;
      timeout <= 1'b0;
    end else begin
      timeout <= 1'b0;
      if (rd_push) begin
        // New read restarts the count
        pending <= 1'b1;
        wd_cnt  <= '0;
      end else if (rr_push) begin
        pending <= 1'b0;
        wd_cnt  <= '0;
      end else if (pending) begin
        if (wd_cnt + 1'b1 == timeout_lim) begin
          timeout <= 1'b1;
          pending <= 1'b0;
          wd_cnt  <= '0;
        end else begin
          wd_cnt <= wd_cnt + 1'b1;
        end
      end
    end
  end

  // Sticky timeout count, any status write clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      timeout_cnt <= '0;
    end else if (apb_wr && reg_sel == REG_STATUS) begin
      timeout_cnt <= '0;
    end else if (timeout) begin
      timeout_cnt <= timeout_cnt + 1'b1;
    end
  end

endmodule

/* rtl/erx_disty.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module erx_disty (
  // From IO
  input  logic                     erx_access,
  input  emesh_pkg::emesh_packet_t erx_packet,
  output logic                     erx_wait,
  output logic                     rx_rd_wait,
  output logic                     rx_wr_wait,
  // Into MMU
  output logic                     mmu_in_access,
  output emesh_pkg::emesh_packet_t mmu_in_packet,
  input  logic                     mmu_in_wait,
  // Out of MMU
  input  logic                     emmu_access,
  input  emesh_pkg::emesh_packet_t emmu_packet,
  output logic                     emmu_wait,
  // From DMA
  input  logic                     edma_access,
  input  emesh_pkg::emesh_packet_t edma_packet,
  output logic                     edma_wait,
  // Master write FIFO
  output logic                     wr_fifo_access,
  output emesh_pkg::emesh_packet_t wr_fifo_packet,
  input  logic                     wr_fifo_wait,
  // Master read FIFO
  output logic                     rd_fifo_access,
  output emesh_pkg::emesh_packet_t rd_fifo_packet,
  input  logic                     rd_fifo_wait,
  // Slave read-response FIFO
  output logic                     rr_fifo_access,
  output emesh_pkg::emesh_packet_t rr_fifo_packet,
  input  logic                     rr_fifo_wait,
  // Watchdog
  input  logic                     timeout,
  output logic                     rr_push
);
  import emesh_pkg::*;

  logic          rr_hit;
  logic          emmu_read;
  emesh_packet_t err_pkt;

  // ####################################################################
  // Read-response detect on the raw stream
  // ####################################################################

  // Write to our own RXRR register
  assign rr_hit = erx_packet.write &
                  (erx_packet.dstaddr[31:20] == `ELINK_ID) &
                  (erx_packet.dstaddr[19:16] == `ELINK_GROUP_RX) &
                  (erx_packet.dstaddr[5:2] == `ELINK_RXRR_OFS);

  // Fixed answer for a read nobody responded to
  assign err_pkt = '{srcaddr: 32'h0, data: `ELINK_ERR_DATA,
                     dstaddr: {`ELINK_ID, `ELINK_GROUP_RX, 16'h0},
                     ctrlmode: 4'h0, datamode: DM_WORD, write: 1'b1, spare: 1'b0};

  // Timeout owns the response FIFO input for its cycle
  assign rr_push        = erx_access & rr_hit & ~erx_wait;
  assign rr_fifo_access = timeout | rr_push;
  assign rr_fifo_packet = timeout ? err_pkt : erx_packet;

  // Everything else goes through the MMU
  assign mmu_in_access = erx_access & ~rr_hit & ~erx_wait;
  assign mmu_in_packet = erx_packet;

  // ####################################################################
  // Write and read steering after the MMU
  // ####################################################################

  assign emmu_read      = emmu_access & ~emmu_packet.write;
  assign wr_fifo_access = emmu_access & emmu_packet.write;
  assign wr_fifo_packet = emmu_packet;

  // MMU read wins over DMA
  assign rd_fifo_access = emmu_read | edma_access;
  assign rd_fifo_packet = emmu_read ? emmu_packet : edma_packet;

  // ####################################################################
  // Wait combining
  // ####################################################################

  assign emmu_wait  = emmu_access & (emmu_packet.write ? wr_fifo_wait : rd_fifo_wait);
  assign edma_wait  = rd_fifo_wait | emmu_read;
  assign rx_rd_wait = rd_fifo_wait;
  // Response writes also stall behind a timeout
  assign rx_wr_wait = wr_fifo_wait | rr_fifo_wait | timeout;
  assign erx_wait   = rx_rd_wait | rx_wr_wait | mmu_in_wait;

endmodule

/* rtl/erx_core.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module erx_core (
  input  logic                 clk,
  input  logic                 rst,
  // Link input
  input  logic                 erx_access,
  input  logic [`ELINK_PW-1:0] erx_packet,
  output logic                 erx_wait,
  output logic                 rx_rd_wait,
  output logic                 rx_wr_wait,
  // DMA input
  input  logic                 edma_access,
  input  logic [`ELINK_PW-1:0] edma_packet,
  output logic                 edma_wait,
  // Master write queue
  output logic                 wr_access,
  output logic [`ELINK_PW-1:0] wr_packet,
  input  logic                 wr_wait,
  // Master read queue
  output logic                 rd_access,
  output logic [`ELINK_PW-1:0] rd_packet,
  input  logic                 rd_wait,
  // Slave read-response queue
  output logic                 rr_access,
  output logic [`ELINK_PW-1:0] rr_packet,
  input  logic                 rr_wait,
  // APB
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [7:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr
);
  import emesh_pkg::*;

  // Typed views of the flat ports
  emesh_packet_t erx_pkt, edma_pkt;
  emesh_packet_t wr_out_pkt, rd_out_pkt, rr_out_pkt;
  // MMU links
  logic          mmu_in_access, mmu_in_wait;
  emesh_packet_t mmu_in_packet;
  logic          emmu_access, emmu_wait;
  emesh_packet_t emmu_packet;
  logic          mmu_enable, mmu_tbl_we;
  logic [3:0]    mmu_tbl_idx;
  logic [11:0]   mmu_tbl_data, mmu_tbl_rdata;
  // FIFO push sides
  logic          wr_fifo_access, wr_fifo_wait;
  logic          rd_fifo_access, rd_fifo_wait;
  logic          rr_fifo_access, rr_fifo_wait;
  emesh_packet_t wr_fifo_packet, rd_fifo_packet, rr_fifo_packet;
  // Watchdog events
  logic          timeout, rr_push, rd_push;

  assign erx_pkt   = emesh_packet_t'(erx_packet);
  assign edma_pkt  = emesh_packet_t'(edma_packet);
  assign wr_packet = wr_out_pkt;
  assign rd_packet = rd_out_pkt;
  assign rr_packet = rr_out_pkt;

  // Any accepted read push arms the watchdog
  assign rd_push = rd_fifo_access & ~rd_fifo_wait;

  erx_cfg i_cfg (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .mmu_enable, .mmu_tbl_we, .mmu_tbl_idx, .mmu_tbl_data, .mmu_tbl_rdata,
    .rd_push, .rr_push, .timeout
  );

  erx_mmu i_mmu (
    .clk, .rst,
    .in_access(mmu_in_access), .in_packet(mmu_in_packet), .in_wait(mmu_in_wait),
    .out_access(emmu_access), .out_packet(emmu_packet), .out_wait(emmu_wait),
    .mmu_enable, .tbl_we(mmu_tbl_we), .tbl_idx(mmu_tbl_idx),
    .tbl_data(mmu_tbl_data), .tbl_rdata(mmu_tbl_rdata)
  );

  erx_disty i_disty (
    .erx_access, .erx_packet(erx_pkt), .erx_wait, .rx_rd_wait, .rx_wr_wait,
    .mmu_in_access, .mmu_in_packet, .mmu_in_wait,
    .emmu_access, .emmu_packet, .emmu_wait,
    .edma_access, .edma_packet(edma_pkt), .edma_wait,
    .wr_fifo_access, .wr_fifo_packet, .wr_fifo_wait,
    .rd_fifo_access, .rd_fifo_packet, .rd_fifo_wait,
    .rr_fifo_access, .rr_fifo_packet, .rr_fifo_wait,
    .timeout, .rr_push
  );

  // ####################################################################
  // Output queues
  // ####################################################################

  erx_fifo #(.DEPTH(`ELINK_FIFO_DEPTH)) i_wr_fifo (
    .clk, .rst,
    .in_access(wr_fifo_access), .in_packet(wr_fifo_packet), .in_wait(wr_fifo_wait),
    .out_access(wr_access), .out_packet(wr_out_pkt), .out_wait(wr_wait)
  );

  erx_fifo #(.DEPTH(`ELINK_FIFO_DEPTH)) i_rd_fifo (
    .clk, .rst,
    .in_access(rd_fifo_access), .in_packet(rd_fifo_packet), .in_wait(rd_fifo_wait),
    .out_access(rd_access), .out_packet(rd_out_pkt), .out_wait(rd_wait)
  );

  erx_fifo #(.DEPTH(`ELINK_FIFO_DEPTH)) i_rr_fifo (
    .clk, .rst,
    .in_access(rr_fifo_access), .in_packet(rr_fifo_packet), .in_wait(rr_fifo_wait),
    .out_access(rr_access), .out_packet(rr_out_pkt), .out_wait(rr_wait)
  );

endmodule

/* verification/erx_checker.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module erx_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 erx_access,
  input  logic [`ELINK_PW-1:0] erx_packet,
  input  logic                 erx_wait,
  input  logic                 rx_rd_wait,
  input  logic                 rx_wr_wait,
  input  logic                 edma_access,
  input  logic [`ELINK_PW-1:0] edma_packet,
  input  logic                 edma_wait,
  input  logic                 wr_access,
  input  logic [`ELINK_PW-1:0] wr_packet,
  input  logic                 wr_wait,
  input  logic                 rd_access,
  input  logic [`ELINK_PW-1:0] rd_packet,
  input  logic                 rd_wait,
  input  logic                 rr_access,
  input  logic [`ELINK_PW-1:0] rr_packet,
  input  logic                 rr_wait,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [7:0]           paddr,
  input  logic [31:0]          pwdata,
  input  logic [31:0]          prdata,
  input  logic                 pready,
  input  logic                 pslverr,
  input  logic                 end_check,
  output logic                 end_done,
  output int                   errors
);
  import emesh_pkg::*;

  // Expected contents of the three output queues
  emesh_packet_t exp_wr[$];
  emesh_packet_t exp_rd[$];
  emesh_packet_t exp_rr[$];
  // Reads sitting in the MMU slot
  emesh_packet_t staged[$];
  emesh_packet_t pkt;
  emesh_packet_t exp_pkt;
  // Register mirror
  logic [11:0]   mirror [16];
  logic          mmu_on;
  logic [31:0]   lim;
  // Watchdog model
  logic          pending;
  logic [31:0]   cnt;
  logic          to_now;
  logic          to_next;
  logic [15:0]   to_count;
  logic          rd_push;
  logic          rd_full;
  logic [31:0]   exp_data;

  function automatic logic own_response(emesh_packet_t p);
    return p.write && (p.dstaddr[31:20] == `ELINK_ID) &&
           (p.dstaddr[19:16] == `ELINK_GROUP_RX) && (p.dstaddr[5:2] == `ELINK_RXRR_OFS);
  endfunction

  // Upper address bits swapped for the table entry of the region
  function automatic emesh_packet_t translate(emesh_packet_t p);
    emesh_packet_t q;
    q = p;
    if (mmu_on) q.dstaddr[31:20] = mirror[p.dstaddr[31:28]];
    return q;
  endfunction

  function automatic emesh_packet_t error_response();
    emesh_packet_t e;
    e = '0;
    e.data     = `ELINK_ERR_DATA;
    e.dstaddr  = {`ELINK_ID, `ELINK_GROUP_RX, 16'h0};
    e.datamode = DM_WORD;
    e.write    = 1'b1;
    return e;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      exp_wr.delete();
      exp_rd.delete();
      exp_rr.delete();
      staged.delete();
      mmu_on   = 1'b0;
      lim      = `ELINK_TIMEOUT_DEF;
      pending  = 1'b0;
      cnt      = '0;
      to_now   = 1'b0;
      to_count = '0;
      end_done <= 1'b0;
      errors   = 0;
    end else begin
      // Read queue level as it stood before this edge
      rd_full = (exp_rd.size() == `ELINK_FIFO_DEPTH);

      // ####################################################################
      // Pops first, they only see older pushes
      // ####################################################################
      if (wr_access && !wr_wait) begin
        if (exp_wr.size() == 0) begin
          $display("ERROR @%0t: write queue popped %h with nothing expected", $time, wr_packet);
          errors = errors + 1;
        end else begin
          exp_pkt = exp_wr.pop_front();
          if (wr_packet !== exp_pkt) begin
            $display("ERROR @%0t: write queue got %h, expected %h", $time, wr_packet, exp_pkt);
            errors = errors + 1;
          end
        end
      end
      if (rd_access && !rd_wait) begin
        if (exp_rd.size() == 0) begin
          $display("ERROR @%0t: read queue popped %h with nothing expected", $time, rd_packet);
          errors = errors + 1;
        end else begin
          exp_pkt = exp_rd.pop_front();
          if (rd_packet !== exp_pkt) begin
            $display("ERROR @%0t: read queue got %h, expected %h", $time, rd_packet, exp_pkt);
            errors = errors + 1;
          end
        end
      end
      if (rr_access && !rr_wait) begin
        if (exp_rr.size() == 0) begin
          $display("ERROR @%0t: response queue popped %h with nothing expected",
                   $time, rr_packet);
          errors = errors + 1;
        end else begin
          exp_pkt = exp_rr.pop_front();
          if (rr_packet !== exp_pkt) begin
            $display("ERROR @%0t: response queue got %h, expected %h",
                     $time, rr_packet, exp_pkt);
            errors = errors + 1;
          end
        end
      end

      // ####################################################################
      // Pushes in link order
      // ####################################################################
      rd_push = 1'b0;
      // MMU read goes ahead of DMA once the read queue has room
      if (staged.size() != 0 && !rd_full) begin
        exp_rd.push_back(staged.pop_front());
        rd_push = 1'b1;
      end
      if (edma_access && !edma_wait) begin
        exp_rd.push_back(emesh_packet_t'(edma_packet));
        rd_push = 1'b1;
      end
      if (to_now) exp_rr.push_back(error_response());
      pkt = emesh_packet_t'(erx_packet);
      if (erx_access && !erx_wait) begin
        if (own_response(pkt)) exp_rr.push_back(pkt);
        else if (pkt.write) exp_wr.push_back(translate(pkt));
        else staged.push_back(translate(pkt));
      end

      // Either per-type wait has to stall the link
      if ((rx_rd_wait || rx_wr_wait) && !erx_wait) begin
        $display("ERROR @%0t: erx_wait low with rx_rd_wait %b rx_wr_wait %b",
                 $time, rx_rd_wait, rx_wr_wait);
        errors = errors + 1;
      end

      // ####################################################################
      // APB readback against register state before this edge
      // ####################################################################
      if (psel && penable && (!pready || pslverr)) begin
        $display("ERROR @%0t: APB access at %h with pready %b pslverr %b",
                 $time, paddr, pready, pslverr);
        errors = errors + 1;
      end
      if (psel && penable && !pwrite) begin
        if (paddr[7:6] == 2'b01) exp_data = {20'h0, mirror[paddr[5:2]]};
        else if (paddr[7:2] == 6'd0) exp_data = {31'h0, mmu_on};
        else if (paddr[7:2] == 6'd1) exp_data = lim;
        else if (paddr[7:2] == 6'd2) exp_data = {to_count, 15'h0, pending};
        else exp_data = 32'h0;
        if (prdata !== exp_data) begin
          $display("ERROR @%0t: APB read at %h got %h, expected %h",
                   $time, paddr, prdata, exp_data);
          errors = errors + 1;
        end
      end

      // Watchdog
      to_next = 1'b0;
      if (rd_push) begin
        pending = 1'b1;
        cnt     = '0;
      end else if (erx_access && !erx_wait && own_response(pkt)) begin
        pending = 1'b0;
        cnt     = '0;
      end else if (pending) begin
        if (cnt + 32'd1 == lim) begin
          to_next = 1'b1;
          pending = 1'b0;
          cnt     = '0;
        end else begin
          cnt = cnt + 32'd1;
        end
      end

      // Register mirror
      if (psel && penable && pwrite && paddr[7:2] == 6'd2) to_count = '0;
      else if (to_now) to_count = to_count + 16'd1;
      if (psel && penable && pwrite) begin
        if (paddr[7:6] == 2'b01) mirror[paddr[5:2]] = pwdata[11:0];
        else if (paddr[7:2] == 6'd0) mmu_on = pwdata[0];
        else if (paddr[7:2] == 6'd1) lim = pwdata;
      end
      to_now = to_next;

      // Anything still expected at the end never left the design
      if (end_check && !end_done) begin
        if (exp_wr.size() + exp_rd.size() + exp_rr.size() + staged.size() != 0) begin
          $display("Packets lost: %0d write, %0d read, %0d response never came out",
                   exp_wr.size(), exp_rd.size() + staged.size(), exp_rr.size());
          errors = errors + 1;
        end
        end_done <= 1'b1;
      end
    end
  end

endmodule

/* verification/tb_erx.sv */
`timescale 1ns/1ps
`include "elink_consts.svh"

module tb_erx;
  import emesh_pkg::*;

  logic                 clk;
  logic                 rst;
  logic                 erx_access, edma_access;
  logic [`ELINK_PW-1:0] erx_packet, edma_packet;
  logic                 erx_wait, rx_rd_wait, rx_wr_wait, edma_wait;
  logic                 wr_access, rd_access, rr_access;
  logic [`ELINK_PW-1:0] wr_packet, rd_packet, rr_packet;
  logic                 wr_wait, rd_wait, rr_wait;
  logic                 psel, penable, pwrite, pready, pslverr;
  logic [7:0]           paddr;
  logic [31:0]          pwdata, prdata;
  logic                 end_check, end_done;
  int                   errors;
  int                   hung;
  integer               seed;
  integer               r;

  erx_core i_erx_core (.*);

  erx_checker i_checker (
    .clk, .rst, .erx_access, .erx_packet, .erx_wait, .rx_rd_wait, .rx_wr_wait,
    .edma_access, .edma_packet, .edma_wait,
    .wr_access, .wr_packet, .wr_wait, .rd_access, .rd_packet, .rd_wait,
    .rr_access, .rr_packet, .rr_wait,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .end_check, .end_done, .errors
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ####################################################################
  // Stimulus helpers
  // ####################################################################

  function automatic logic [`ELINK_PW-1:0] make_packet(logic [31:0] dst, logic wr);
    emesh_packet_t p;
    integer a;
    integer b;
    a = $random(seed);
    b = $random(seed);
    p.srcaddr  = a;
    p.data     = b;
    p.dstaddr  = dst;
    p.ctrlmode = a[3:0];
    p.datamode = emesh_datamode_e'(b[1:0]);
    p.write    = wr;
    p.spare    = 1'b0;
    return p;
  endfunction

  // Write, read or response to our own register
  function automatic logic [`ELINK_PW-1:0] link_packet();
    integer k;
    integer d;
    k = $random(seed);
    d = $random(seed);
    if (k[1:0] == 2'b00)
      return make_packet({`ELINK_ID, `ELINK_GROUP_RX, d[9:0], `ELINK_RXRR_OFS, 2'b00}, 1'b1);
    return make_packet(d, k[2]);
  endfunction

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    int guard;
    guard = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (!pready && guard < 16) begin
      @(posedge clk);
      guard++;
    end
    if (!pready) begin
      $display("Timeout: APB slave never raised pready at address %h", addr);
      hung++;
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic run_traffic(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      r = $random(seed);
      // Random back-pressure on the three consumers
      wr_wait <= (r[1:0] == 2'b00);
      rd_wait <= (r[3:2] == 2'b00);
      rr_wait <= (r[5:4] == 2'b00);
      if (!erx_access || !erx_wait) begin
        erx_access <= r[6];
        erx_packet <= link_packet();
      end
      if (!edma_access || !edma_wait) begin
        edma_access <= (r[9:7] == 3'b000);
        edma_packet <= make_packet($random(seed), 1'b0);
      end
    end
  endtask

  // Held packets finish before access drops
  task automatic stop_sources();
    int guard;
    guard = 0;
    wr_wait <= 1'b0;
    rd_wait <= 1'b0;
    rr_wait <= 1'b0;
    do begin
      @(posedge clk);
      if (!erx_wait) erx_access <= 1'b0;
      if (!edma_wait) edma_access <= 1'b0;
      guard++;
    end while ((erx_access || edma_access) && guard < 200);
    if (erx_access || edma_access) begin
      $display("Timeout: a source packet was never accepted");
      hung++;
    end
  endtask

  // Quiet outputs for a few cycles in a row means the design is empty
  task automatic drain();
    int guard;
    int quiet;
    guard = 0;
    quiet = 0;
    while (quiet < 4 && guard < 500) begin
      @(posedge clk);
      if (wr_access || rd_access || rr_access) quiet = 0;
      else quiet++;
      guard++;
    end
    if (quiet < 4) begin
      $display("Timeout: output queues did not drain");
      hung++;
    end
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial begin
    int guard;
    seed        = 76;
    hung        = 0;
    rst         = 1'b1;
    erx_access  = 1'b0;
    erx_packet  = '0;
    edma_access = 1'b0;
    edma_packet = '0;
    wr_wait     = 1'b0;
    rd_wait     = 1'b0;
    rr_wait     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    end_check   = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Watchdog out of the way for the random phase
    apb_xfer(1'b1, 8'h04, 32'hFFFF_FFFF);
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      apb_xfer(1'b1, {2'b01, i[3:0], 2'b00}, {20'h0, r[11:0]});
    end
    apb_xfer(1'b1, 8'h00, 32'h1);
    apb_xfer(1'b0, 8'h00, 32'h0);
    apb_xfer(1'b0, 8'h04, 32'h0);
    for (int i = 0; i < 16; i++) apb_xfer(1'b0, {2'b01, i[3:0], 2'b00}, 32'h0);

    // Remapped traffic, then pass-through traffic
    run_traffic(400);
    stop_sources();
    drain();
    apb_xfer(1'b1, 8'h00, 32'h0);
    run_traffic(300);
    stop_sources();
    drain();

    // One DMA read left unanswered
    apb_xfer(1'b1, 8'h04, 32'd20);
    apb_xfer(1'b1, 8'h08, 32'h0);
    @(posedge clk);
    edma_access <= 1'b1;
    edma_packet <= make_packet(32'h1000_0040, 1'b0);
    stop_sources();
    guard = 0;
    while (!rr_access && guard < 200) begin
      @(posedge clk);
      guard++;
    end
    if (!rr_access) begin
      $display("Timeout: watchdog never produced an error response");
      hung++;
    end
    drain();
    apb_xfer(1'b0, 8'h08, 32'h0);

    end_check <= 1'b1;
    guard = 0;
    @(posedge clk);
    while (!end_done && guard < 20) begin
      @(posedge clk);
      guard++;
    end
    if (!end_done) begin
      $display("Timeout: checker never finished its final check");
      hung++;
    end

    $display("Errors: %0d, timeouts: %0d", errors, hung);
    if (errors == 0 && hung == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
rtl/emesh_pkg.sv
rtl/erx_fifo.sv
rtl/erx_mmu.sv
rtl/erx_cfg.sv
rtl/erx_disty.sv
rtl/erx_core.sv
verification/erx_checker.sv
verification/tb_erx.sv

/* run.sh */
#!/bin/sh
# Build and run the erx_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_erx -f tb.f -o sim_erx \
  && ./obj_dir/sim_erx > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
